//--- src/displayPkg.sv
//--------------------
// Display types
// Raster coordinates, pixel words and colour modes
// shared by the pixel path
//--------------------
package displayPkg;

    //--------------------
    // Plain widths
    //--------------------
    typedef logic [23:0] pixelT;    // RGB, red in [23:16], blue in [7:0]
    typedef logic [11:0] coordT;    // Raster x or y
    typedef logic [7:0]  frameT;    // Frame count, feeds blue

    // Colour operation select
    // Only changed while rstN is low
    typedef enum logic [1:0] {
        opPass   = 2'd0,            // Pixel unchanged
        opInvert = 2'd1,            // All 24 bits complemented
        opSwapRb = 2'd2             // Red and blue bytes exchanged
    } opModeT;

    //--------------------
    // FIFO payload
    //--------------------
    typedef struct packed {
        pixelT pixel;               // Colour
        logic  frameStart;          // High on x=0 y=0
    } pixelWordT;                   // 25 bits

endpackage

//--- src/bufferPkg.sv
//--------------------
// Buffer types
// FIFO pointer type and gray-code helpers
//--------------------
package bufferPkg;

    // Wide enough for 32768 entries plus wrap bit
    typedef logic [15:0] ptrT;

    // Binary to gray
    function automatic ptrT toGray(input ptrT bin);
        return bin ^ (bin >> 1);
    endfunction

    // Gray to binary, ripple from the top bit down
    function automatic ptrT fromGray(input ptrT gray);
        ptrT bin;
        bin[$bits(ptrT)-1] = gray[$bits(ptrT)-1];
        for (int i = $bits(ptrT) - 2; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

//--- src/pixelGenerator.sv
//--------------------
// Pixel generator
// Walks the raster and builds a test pattern pixel
// per position, stalled while cke is low
//--------------------
`timescale 1ns/1ns

module pixelGenerator
    import displayPkg::*;
#(
    parameter int hDisplay = 640,       // Raster width
    parameter int vDisplay = 480        // Raster height
)(
    input  logic      sysClk,           // System clock
    input  logic      rstN,             // Async reset, active low
    input  logic      cke,              // Advance enable, low when FIFO full
    output pixelWordT genWord,          // Pattern pixel plus frame mark
    output logic      genValid          // genWord holds a pixel
);

    //--------------------
    // Raster position
    //--------------------
    localparam coordT xLast = coordT'(hDisplay - 1);
    localparam coordT yLast = coordT'(vDisplay - 1);

    coordT xPos;                        // Position of the next pixel
    coordT yPos;
    frameT frameCnt;                    // Frames since reset

    logic  xWrap;
    logic  yWrap;

    assign xWrap = (xPos == xLast);     // End of line
    assign yWrap = (yPos == yLast);     // Last line of frame

    // Counters point one pixel ahead of genWord
    always_ff @(posedge sysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            xPos     <= '0;
            yPos     <= '0;
            frameCnt <= '0;
            genValid <= 1'b0;
        end
        else if (cke)
        begin
            genValid <= 1'b1;           // Stays up once running
            if (xWrap)
            begin
                xPos <= '0;
                if (yWrap)
                begin
                    yPos     <= '0;
                    frameCnt <= frameCnt + 1'b1;    // Wraps at 256
                end
                else
                begin
                    yPos <= yPos + 1'b1;
                end
            end
            else
            begin
                xPos <= xPos + 1'b1;
            end
        end
    end

    //--------------------
    // Pattern builder
    //--------------------
    // Red from x, green from y, blue from frame
    function automatic pixelT buildPixel(input coordT x, input coordT y, input frameT f);
        return {x[7:0], y[7:0], f};
    endfunction

    // Output word, held under stall
    always_ff @(posedge sysClk)
    begin
        if (cke)
        begin
            genWord.pixel      <= buildPixel(xPos, yPos, frameCnt);
            genWord.frameStart <= (xPos == '0) && (yPos == '0);
        end
    end

endmodule

//--- src/pixelOperation.sv
//--------------------
// Pixel operation
// Two-stage colour pipeline: pass, invert or
// red/blue swap, held while cke is low
//--------------------
`timescale 1ns/1ns

module pixelOperation
    import displayPkg::*;
(
    input  logic      sysClk,           // System clock
    input  logic      rstN,             // Async reset, active low
    input  logic      cke,              // Stage enable, low when FIFO full
    input  opModeT    opMode,           // Colour operation, quasi-static
    input  pixelWordT genWord,          // From generator
    input  logic      genValid,
    output pixelWordT opWord,           // Toward FIFO
    output logic      opValid
);

    //--------------------
    // Stage one
    //--------------------
    pixelWordT s1Word;                  // Registered input word
    logic      s1Valid;
    logic      s1Invert;                // Decoded mode flags
    logic      s1Swap;

    // Apply the decoded operation to one pixel
    function automatic pixelT applyOp(input pixelT p, input logic inv, input logic swap);
        pixelT result;
        result = p;
        if (inv)
        begin
            result = ~p;                // All three bytes
        end
        else if (swap)
        begin
            result = {p[7:0], p[15:8], p[23:16]};   // Blue, green, red
        end
        return result;
    endfunction

    // Valid bits, one per stage
    always_ff @(posedge sysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            s1Valid <= 1'b0;
            opValid <= 1'b0;
        end
        else if (cke)
        begin
            s1Valid <= genValid;
            opValid <= s1Valid;
        end
    end

    // Stage one: capture word and decode mode
    always_ff @(posedge sysClk)
    begin
        if (cke)
        begin
            s1Word   <= genWord;
            s1Invert <= (opMode == opInvert);
            s1Swap   <= (opMode == opSwapRb);
        end
    end

    //--------------------
    // Stage two
    //--------------------
    always_ff @(posedge sysClk)
    begin
        if (cke)
        begin
            opWord.pixel      <= applyOp(s1Word.pixel, s1Invert, s1Swap);
            opWord.frameStart <= s1Word.frameStart;     // Mark passes unchanged
        end
    end

endmodule

//--- src/pixelFifo.sv
//--------------------
// Pixel async FIFO
// Crosses pixel words from sysClk to pixelClk
// with gray pointers, drained by fvde
//--------------------
`timescale 1ns/1ns

module pixelFifo
    import displayPkg::*;
    import bufferPkg::*;
#(
    parameter int buffDepth = 1024      // Entries, power of two
)(
    input  logic      sysClk,           // Write clock
    input  logic      pixelClk,         // Read clock
    input  logic      rstN,             // Async reset, both domains
    input  pixelWordT wrWord,           // Write data
    input  logic      wrEn,             // Write request
    output logic      full,             // Write side full
    input  logic      fvde,             // Read strobe, fast video enable
    output pixelT     pixel,            // Registered read pixel
    output logic      frameStart,       // Registered frame mark
    output logic      pixelValid        // One cycle per word read
);

    localparam int  addrW   = $clog2(buffDepth);
    localparam ptrT ptrMask = ptrT'(2 * buffDepth - 1);     // Address plus wrap bit

    pixelWordT mem [buffDepth];         // Storage, no reset

    // Read domain state
    ptrT  rdPtr;
    ptrT  rdPtrNext;
    ptrT  rdGray;
    ptrT  wrGraySync1;                  // Write pointer, first flop
    ptrT  wrGraySync2;                  // Write pointer, second flop
    logic empty;
    logic rdFire;

    //--------------------
    // Write domain
    //--------------------
    ptrT  wrPtr;                        // Binary, wraps at 2*depth
    ptrT  wrPtrNext;
    ptrT  wrGray;                       // Registered gray copy
    ptrT  rdGraySync1;                  // Read pointer, first flop
    ptrT  rdGraySync2;                  // Read pointer, second flop
    ptrT  rdPtrSync;                    // Read pointer back in binary
    logic wrFire;

    assign wrFire    = wrEn && !full;
    assign wrPtrNext = (wrPtr + 1'b1) & ptrMask;
    assign rdPtrSync = fromGray(rdGraySync2);

    // Wrap bits differ, addresses match
    assign full = (wrPtr[addrW] != rdPtrSync[addrW]) &&
                  (wrPtr[addrW-1:0] == rdPtrSync[addrW-1:0]);

    always_ff @(posedge sysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr  <= '0;
            wrGray <= '0;
        end
        else if (wrFire)
        begin
            wrPtr  <= wrPtrNext;
            wrGray <= toGray(wrPtrNext);
        end
    end

    // Read pointer into write domain
    always_ff @(posedge sysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end
        else
        begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
        end
    end

    always_ff @(posedge sysClk)
    begin
        if (wrFire)
        begin
            mem[wrPtr[addrW-1:0]] <= wrWord;
        end
    end

    //--------------------
    // Read domain
    //--------------------
    assign empty     = (rdGray == wrGraySync2);     // Gray codes equal
    assign rdFire    = fvde && !empty;
    assign rdPtrNext = (rdPtr + 1'b1) & ptrMask;

    always_ff @(posedge pixelClk or negedge rstN)
    begin
        if (!rstN)
        begin
            rdPtr       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            pixelValid  <= 1'b0;
        end
        else
        begin
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            pixelValid  <= rdFire;      // Low on an empty strobe
            if (rdFire)
            begin
                rdPtr  <= rdPtrNext;
                rdGray <= toGray(rdPtrNext);
            end
        end
    end

    // Read port, holds when nothing is read
    always_ff @(posedge pixelClk)
    begin
        if (rdFire)
        begin
            pixel      <= mem[rdPtr[addrW-1:0]].pixel;
            frameStart <= mem[rdPtr[addrW-1:0]].frameStart;
        end
    end

endmodule

//--- src/pixelPipeline.sv
//--------------------
// Pixel pipeline
// Generator, colour operation and async FIFO
//--------------------
`timescale 1ns/1ns

module pixelPipeline
    import displayPkg::*;
#(
    parameter int hDisplay  = 640,      // Raster width
    parameter int vDisplay  = 480,      // Raster height
    parameter int buffDepth = 1024      // FIFO depth, power of two
)(
    input  logic   sysClk,              // System clock
    input  logic   pixelClk,            // Pixel clock
    input  logic   rstN,                // Async reset, active low
    input  opModeT opMode,              // Colour operation
    input  logic   fvde,                // Fast video enable, pixelClk domain
    output pixelT  pixel,               // Display pixel
    output logic   frameStart,          // First pixel of a frame
    output logic   pixelValid           // Pixel updated this cycle
);

    //--------------------
    // Internal wiring
    //--------------------
    pixelWordT genWord;
    logic      genValid;
    pixelWordT opWord;
    logic      opValid;
    logic      full;
    logic      cke;

    assign cke = ~full;                 // Whole system side stalls on full

    pixelGenerator #(
        .hDisplay   (hDisplay),
        .vDisplay   (vDisplay)
    ) PGB (
        .sysClk     (sysClk),
        .rstN       (rstN),
        .cke        (cke),
        .genWord    (genWord),
        .genValid   (genValid)
    );

    pixelOperation ROB (
        .sysClk     (sysClk),
        .rstN       (rstN),
        .cke        (cke),
        .opMode     (opMode),
        .genWord    (genWord),
        .genValid   (genValid),
        .opWord     (opWord),
        .opValid    (opValid)
    );

    pixelFifo #(
        .buffDepth  (buffDepth)
    ) PFB (
        .sysClk     (sysClk),
        .pixelClk   (pixelClk),
        .rstN       (rstN),
        .wrWord     (opWord),
        .wrEn       (opValid & cke),    // Write only while the pipe moves
        .full       (full),
        .fvde       (fvde),
        .pixel      (pixel),
        .frameStart (frameStart),
        .pixelValid (pixelValid)
    );

endmodule

//--- tb/pixelFifo_props.sv
//--------------------
// FIFO properties
// Overflow, empty read and reset checks
//--------------------
`timescale 1ns/1ns

module pixelFifoProps
    import bufferPkg::*;
#(
    parameter int buffDepth = 1024      // Entries, power of two
)(
    input logic sysClk,
    input logic pixelClk,
    input logic rstN,
    input logic empty,
    input ptrT  wrPtr,                  // Binary write pointer
    input ptrT  rdPtr,                  // Binary read pointer
    input logic pixelValid
);

    localparam ptrT ptrMask = ptrT'(2 * buffDepth - 1);

    // Unread words never exceed the depth
    noWriteWhenFull: assert property (@(posedge sysClk) disable iff (!rstN)
        ((wrPtr - rdPtr) & ptrMask) <= ptrT'(buffDepth))
    else $error("Write accepted while the FIFO was full");

    // Empty strobe gives no valid
    noReadWhenEmpty: assert property (@(posedge pixelClk) disable iff (!rstN)
        empty |=> !pixelValid)
    else $error("pixelValid rose after an empty cycle");

    // Quiet under reset
    quietInReset: assert property (@(posedge pixelClk) !rstN |-> !pixelValid)
    else $error("pixelValid high during reset");

endmodule

bind pixelFifo pixelFifoProps #(
    .buffDepth  (buffDepth)
) PROPS (
    .sysClk     (sysClk),
    .pixelClk   (pixelClk),
    .rstN       (rstN),
    .empty      (empty),
    .wrPtr      (wrPtr),
    .rdPtr      (rdPtr),
    .pixelValid (pixelValid)
);

//--- tb/pixelPipelineTb.sv
//--------------------
// Pixel pipeline testbench
// Random fvde, raster reference model and
// assertion checks over the three colour modes
//--------------------
`timescale 1ns/1ns

module pixelPipelineTb
    import displayPkg::*;
();

    localparam int hDisp          = 8;              // Small raster, 32 pixels a frame
    localparam int vDisp          = 4;
    localparam int depth          = 16;
    localparam int pixelsPerPhase = 3 * hDisp * vDisp;  // Three frames
    localparam int waitLimit      = 5000;           // sysClk cycles per phase
    localparam logic [31:0] lfsrSeed = 32'h3746_a823;

    localparam coordT xLast = coordT'(hDisp - 1);
    localparam coordT yLast = coordT'(vDisp - 1);

    logic   sysClk   = 1'b0;
    logic   pixelClk = 1'b0;
    logic   rstN;
    opModeT opMode;
    logic   fvde;
    pixelT  pixel;
    logic   frameStart;
    logic   pixelValid;

    //--------------------
    // Clocks and DUT
    //--------------------
    always #5 sysClk = ~sysClk;         // 10 ns
    always #7 pixelClk = ~pixelClk;     // 14 ns, unrelated to sysClk

    pixelPipeline #(
        .hDisplay   (hDisp),
        .vDisplay   (vDisp),
        .buffDepth  (depth)
    ) UUT (
        .sysClk     (sysClk),
        .pixelClk   (pixelClk),
        .rstN       (rstN),
        .opMode     (opMode),
        .fvde       (fvde),
        .pixel      (pixel),
        .frameStart (frameStart),
        .pixelValid (pixelValid)
    );

    // Print the failure, then stop the run
    task automatic abortRun(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run aborted");
    endtask

    //--------------------
    // fvde stimulus
    //--------------------
    logic [31:0] lfsr = lfsrSeed;
    logic        bitA;
    logic        bitB;
    int          winCnt;                // Position in the 200-cycle duty window

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always @(posedge pixelClk)
    begin
        if (!rstN)
        begin
            fvde   <= 1'b1;             // Strobing an empty FIFO
            winCnt <= 0;
        end
        else
        begin
            winCnt <= (winCnt == 199) ? 0 : winCnt + 1;
            if (winCnt < 110)
            begin
                lfsr = lfsrNext(lfsr);
                bitA = lfsr[0];
                lfsr = lfsrNext(lfsr);
                bitB = lfsr[0];
                // Mostly high first, then mostly low
                fvde <= (winCnt < 60) ? (bitA | bitB) : (bitA & bitB);
            end
            else
            begin
                fvde <= 1'b0;           // Long idle, FIFO fills and stalls
            end
        end
    end

    //--------------------
    // Reference model
    //--------------------
    coordT mX;                          // Raster position of next expected pixel
    coordT mY;
    frameT mF;
    int    validCount;                  // Pixels checked since reset
    logic  sawFull;                     // FIFO filled in this phase

    // Pattern from raster position, then colour mode
    function automatic pixelT expectPixel(input coordT x, input coordT y,
                                          input frameT f, input opModeT m);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = x[7:0];
        g = y[7:0];
        b = f;
        case (m)
            opInvert: return {~r, ~g, ~b};
            opSwapRb: return {b, g, r};     // Green stays in the middle
            default:  return {r, g, b};
        endcase
    endfunction

    always @(posedge pixelClk)
    begin
        if (!rstN)
        begin
            mX         <= '0;
            mY         <= '0;
            mF         <= '0;
            validCount <= 0;
        end
        else if (pixelValid)
        begin
            assert (pixel == expectPixel(mX, mY, mF, opMode))
            else abortRun($sformatf("ERROR at %0t ns: pixel %h, expected %h (x %0d y %0d f %0d)",
                                    $time, pixel, expectPixel(mX, mY, mF, opMode),
                                    mX, mY, mF));
            validCount <= validCount + 1;
            mX <= (mX == xLast) ? '0 : mX + 1'b1;
            if (mX == xLast)
            begin
                mY <= (mY == yLast) ? '0 : mY + 1'b1;
                if (mY == yLast)
                begin
                    mF <= mF + 1'b1;    // Next frame
                end
            end
        end
    end

    always @(posedge sysClk)
    begin
        if (!rstN)
        begin
            sawFull <= 1'b0;
        end
        else if (UUT.full)
        begin
            sawFull <= 1'b1;
        end
    end

    // frameStart only on the first raster position
    assert property (@(posedge pixelClk) disable iff (!rstN)
        pixelValid |-> (frameStart == ((mX == '0) && (mY == '0))))
    else abortRun($sformatf("ERROR at %0t ns: frameStart does not match model position",
                            $time));

    // No unknown data on a valid cycle
    assert property (@(posedge pixelClk) disable iff (!rstN)
        pixelValid |-> !$isunknown({pixel, frameStart}))
    else abortRun($sformatf("ERROR at %0t ns: unknown pixel on a valid cycle", $time));

    //--------------------
    // Phases
    //--------------------
    task automatic runPhase(input opModeT mode);
        int cycles;
        @(posedge sysClk);
        rstN   <= 1'b0;
        opMode <= mode;                 // Mode changes only under reset
        repeat (4) @(posedge sysClk);
        rstN   <= 1'b1;
        cycles = 0;
        while (validCount < pixelsPerPhase)
        begin
            @(posedge sysClk);
            cycles++;
            if (cycles > waitLimit)
            begin
                abortRun($sformatf("Timeout: %0d of %0d pixels arrived in mode %s",
                                   validCount, pixelsPerPhase, mode.name()));
            end
        end
        assert (sawFull)
        else abortRun("The FIFO never filled, so the stall path was not exercised");
    endtask

    initial
    begin
        rstN   = 1'b0;
        opMode = opPass;
        fvde   = 1'b0;
        runPhase(opPass);
        runPhase(opInvert);
        runPhase(opSwapRb);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- compile.f
src/displayPkg.sv
src/bufferPkg.sv
src/pixelGenerator.sv
src/pixelOperation.sv
src/pixelFifo.sv
src/pixelPipeline.sv
tb/pixelFifo_props.sv
tb/pixelPipelineTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module pixelPipelineTb -f compile.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -F -q "*** TEST PASSED ***" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
